// File: rtl/rv_pkg.sv
package rv_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;
    localparam int n_regs     = 32;
    localparam int funct3_w   = 3;

    localparam logic [xlen-1:0] reset_pc = 32'h0040_0000;

    // Opcode indices, instruction bits 6:2
    localparam logic [4:0] op_op_imm = 5'b00100;
    localparam logic [4:0] op_auipc  = 5'b00101;
    localparam logic [4:0] op_op     = 5'b01100;
    localparam logic [4:0] op_lui    = 5'b01101;

    // ALU function codes, same as funct3
    localparam logic [funct3_w-1:0] alu_add  = 3'd0;
    localparam logic [funct3_w-1:0] alu_sll  = 3'd1;
    localparam logic [funct3_w-1:0] alu_slt  = 3'd2;
    localparam logic [funct3_w-1:0] alu_sltu = 3'd3;
    localparam logic [funct3_w-1:0] alu_xor  = 3'd4;
    localparam logic [funct3_w-1:0] alu_sr   = 3'd5; // SRL or SRA by alt
    localparam logic [funct3_w-1:0] alu_or   = 3'd6;
    localparam logic [funct3_w-1:0] alu_and  = 3'd7;

endpackage

// File: rtl/fetch_unit.sv
module fetch_unit
    import rv_pkg::*;
(
    input  logic            clk,
    input  logic            rst_n,
    output logic [xlen-1:0] icache_addr,
    output logic [xlen-1:0] pc_if,
    output logic            if_valid
);

    logic [xlen-1:0] pc;

    // No stalls, so the PC simply walks forward
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc       <= reset_pc;
            if_valid <= 1'b0;
        end else begin
            pc       <= pc + 32'd4;
            if_valid <= 1'b1;
        end
    end

    // PC of the word now held in ID
    always_ff @(posedge clk) begin
        pc_if <= pc;
    end

    assign icache_addr = pc;

endmodule

// File: rtl/inst_decoder.sv
module inst_decoder
    import rv_pkg::*;
(
    input  logic [xlen-1:0]       icache_data,
    output logic                  supported,
    output logic [reg_addr_w-1:0] rs1_addr_d,
    output logic [reg_addr_w-1:0] rs2_addr_d,
    output logic [reg_addr_w-1:0] rd_d,
    output logic [xlen-1:0]       imm_d,
    output logic                  use_pc,
    output logic                  use_imm,
    output logic [funct3_w-1:0]   funct3_d,
    output logic                  alt_d
);

    logic [31:0]         op_oh;
    logic                is_op;
    logic                is_op_imm;
    logic                is_lui;
    logic                is_auipc;
    logic [funct3_w-1:0] funct3;
    logic [xlen-1:0]     imm_i;
    logic [xlen-1:0]     imm_u;

    always_comb begin
        op_oh = '0;
        op_oh[icache_data[6:2]] = 1'b1;
    end

    assign is_op     = op_oh[op_op];
    assign is_op_imm = op_oh[op_op_imm];
    assign is_lui    = op_oh[op_lui];
    assign is_auipc  = op_oh[op_auipc];
    assign supported = is_op | is_op_imm | is_lui | is_auipc;

    assign funct3 = icache_data[14:12];
    assign imm_i  = {{20{icache_data[31]}}, icache_data[31:20]};
    assign imm_u  = {icache_data[31:12], 12'd0};

    // LUI reads x0, AUIPC reads nothing
    assign rs1_addr_d = (is_op | is_op_imm) ? icache_data[19:15] : '0;
    assign rs2_addr_d = is_op ? icache_data[24:20] : '0;
    assign rd_d       = supported ? icache_data[11:7] : '0;

    assign imm_d = is_op_imm ? imm_i : ((is_lui | is_auipc) ? imm_u : '0);

    assign use_pc  = is_auipc;
    assign use_imm = is_op_imm | is_lui | is_auipc;

    assign funct3_d = (is_op | is_op_imm) ? funct3 : alu_add;
    // SUB/SRA, and SRAI only among the immediates
    assign alt_d = icache_data[30] & (is_op | (is_op_imm & (funct3 == alu_sr)));

endmodule

// File: rtl/id_stage.sv
module id_stage
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  if_valid,
    input  logic                  supported,
    input  logic [xlen-1:0]       pc_if,
    input  logic [reg_addr_w-1:0] rs1_addr_d,
    input  logic [reg_addr_w-1:0] rs2_addr_d,
    input  logic [reg_addr_w-1:0] rd_d,
    input  logic [xlen-1:0]       imm_d,
    input  logic                  use_pc,
    input  logic                  use_imm,
    input  logic [funct3_w-1:0]   funct3_d,
    input  logic                  alt_d,
    output logic [reg_addr_w-1:0] rs1_addr,
    output logic [reg_addr_w-1:0] rs2_addr,
    input  logic [xlen-1:0]       rs1,
    input  logic [xlen-1:0]       rs2,
    input  logic [xlen-1:0]       ex_result,
    input  logic                  wb_valid,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    output logic [xlen-1:0]       alu_a,
    output logic [xlen-1:0]       alu_b,
    output logic [funct3_w-1:0]   alu_funct3,
    output logic                  alu_alt,
    output logic [reg_addr_w-1:0] ex_rd,
    output logic                  ex_valid
);

    logic                  sup_q;
    logic [reg_addr_w-1:0] rd_q;
    logic [xlen-1:0]       imm_q;
    logic                  use_pc_q;
    logic                  use_imm_q;
    logic                  id_valid;
    logic [xlen-1:0]       rs1_fwd;
    logic [xlen-1:0]       rs2_fwd;

    // Newest producer wins
    function automatic logic [xlen-1:0] fwd(input logic [reg_addr_w-1:0] addr,
                                            input logic [xlen-1:0] rf_val);
        logic [xlen-1:0] val;
        if (addr == '0)
            val = '0;
        else if (ex_valid && ex_rd == addr)
            val = ex_result;
        else if (wb_valid && wb_rd == addr)
            val = wb_data;
        else
            val = rf_val;
        return val;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n)
            sup_q <= 1'b0;
        else
            sup_q <= supported;
    end

    always_ff @(posedge clk) begin
        rs1_addr   <= rs1_addr_d;
        rs2_addr   <= rs2_addr_d;
        rd_q       <= rd_d;
        imm_q      <= imm_d;
        use_pc_q   <= use_pc;
        use_imm_q  <= use_imm;
        alu_funct3 <= funct3_d;
        alu_alt    <= alt_d;
    end

    assign id_valid = if_valid & sup_q; // pc_if is already aligned with ID

    always_comb begin
        rs1_fwd = fwd(rs1_addr, rs1);
        rs2_fwd = fwd(rs2_addr, rs2);
    end

    assign alu_a = use_pc_q ? pc_if : rs1_fwd;
    assign alu_b = use_imm_q ? imm_q : rs2_fwd;

    always_ff @(posedge clk) begin
        if (!rst_n)
            ex_valid <= 1'b0;
        else
            ex_valid <= id_valid;
    end

    always_ff @(posedge clk) begin
        ex_rd <= rd_q;
    end

    a_ex_valid_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(ex_valid));

endmodule

// File: rtl/alu.sv
module alu
    import rv_pkg::*;
(
    input  logic                clk,
    input  logic [xlen-1:0]     a,
    input  logic [xlen-1:0]     b,
    input  logic [funct3_w-1:0] funct3,
    input  logic                alt,
    output logic [xlen-1:0]     result
);

    logic [xlen-1:0] r;
    logic [4:0]      shamt;

    assign shamt = b[4:0];

    always_comb begin
        case (funct3)
            alu_add:  r = alt ? a - b : a + b;
            alu_sll:  r = a << shamt;
            alu_slt:  r = {31'd0, $signed(a) < $signed(b)};
            alu_sltu: r = {31'd0, a < b};
            alu_xor:  r = a ^ b;
            alu_sr:   r = alt ? $unsigned($signed(a) >>> shamt) : a >> shamt;
            alu_or:   r = a | b;
            default:  r = a & b; // alu_and
        endcase
    end

    always_ff @(posedge clk) begin
        result <= r; // EX stage output
    end

endmodule

// File: rtl/ma_stage.sv
module ma_stage
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  ex_valid,
    input  logic [reg_addr_w-1:0] ex_rd,
    input  logic [xlen-1:0]       ex_result,
    output logic                  wb_valid,
    output logic [reg_addr_w-1:0] wb_rd,
    output logic [xlen-1:0]       wb_data
);

    always_ff @(posedge clk) begin
        if (!rst_n)
            wb_valid <= 1'b0;
        else
            wb_valid <= ex_valid;
    end

    // Nothing to access in memory, just carry the result
    always_ff @(posedge clk) begin
        wb_rd   <= ex_rd;
        wb_data <= ex_result;
    end

    a_wb_data_known: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid |-> !$isunknown(wb_data));

endmodule

// File: rtl/gpr_file.sv
module gpr_file
    import rv_pkg::*;
(
    input  logic                  clk,
    input  logic [reg_addr_w-1:0] rs1_addr,
    input  logic [reg_addr_w-1:0] rs2_addr,
    output logic [xlen-1:0]       rs1,
    output logic [xlen-1:0]       rs2,
    input  logic                  wb_valid,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data
);

    logic [xlen-1:0] regs [1:n_regs-1]; // no storage for x0

    always_ff @(posedge clk) begin
        if (wb_valid && wb_rd != '0)
            regs[wb_rd] <= wb_data;
    end

    assign rs1 = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2 = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// File: rtl/rv_core.sv
module rv_core (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic [rv_pkg::xlen-1:0]       icache_data,
    output logic [rv_pkg::xlen-1:0]       icache_addr,
    output logic                          wb_valid,
    output logic [rv_pkg::reg_addr_w-1:0] wb_rd,
    output logic [rv_pkg::xlen-1:0]       wb_data
);

    logic [rv_pkg::xlen-1:0]       pc_if;
    logic                          if_valid;
    logic                          supported;
    logic [rv_pkg::reg_addr_w-1:0] rs1_addr_d;
    logic [rv_pkg::reg_addr_w-1:0] rs2_addr_d;
    logic [rv_pkg::reg_addr_w-1:0] rd_d;
    logic [rv_pkg::xlen-1:0]       imm_d;
    logic                          use_pc;
    logic                          use_imm;
    logic [rv_pkg::funct3_w-1:0]   funct3_d;
    logic                          alt_d;
    logic [rv_pkg::reg_addr_w-1:0] rs1_addr;
    logic [rv_pkg::reg_addr_w-1:0] rs2_addr;
    logic [rv_pkg::xlen-1:0]       rs1;
    logic [rv_pkg::xlen-1:0]       rs2;
    logic [rv_pkg::xlen-1:0]       alu_a;
    logic [rv_pkg::xlen-1:0]       alu_b;
    logic [rv_pkg::funct3_w-1:0]   alu_funct3;
    logic                          alu_alt;
    logic [rv_pkg::xlen-1:0]       ex_result;
    logic [rv_pkg::reg_addr_w-1:0] ex_rd;
    logic                          ex_valid;

    fetch_unit u_fetch (
        .clk(clk), .rst_n(rst_n), .icache_addr(icache_addr),
        .pc_if(pc_if), .if_valid(if_valid)
    );

    inst_decoder u_dec (
        .icache_data(icache_data), .supported(supported),
        .rs1_addr_d(rs1_addr_d), .rs2_addr_d(rs2_addr_d), .rd_d(rd_d), .imm_d(imm_d),
        .use_pc(use_pc), .use_imm(use_imm), .funct3_d(funct3_d), .alt_d(alt_d)
    );

    id_stage u_id (
        .clk(clk), .rst_n(rst_n), .if_valid(if_valid), .supported(supported), .pc_if(pc_if),
        .rs1_addr_d(rs1_addr_d), .rs2_addr_d(rs2_addr_d), .rd_d(rd_d), .imm_d(imm_d),
        .use_pc(use_pc), .use_imm(use_imm), .funct3_d(funct3_d), .alt_d(alt_d),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1(rs1), .rs2(rs2),
        .ex_result(ex_result), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data),
        .alu_a(alu_a), .alu_b(alu_b), .alu_funct3(alu_funct3), .alu_alt(alu_alt),
        .ex_rd(ex_rd), .ex_valid(ex_valid)
    );

    alu u_alu (
        .clk(clk), .a(alu_a), .b(alu_b), .funct3(alu_funct3), .alt(alu_alt),
        .result(ex_result)
    );

    ma_stage u_ma (
        .clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_result(ex_result),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    gpr_file u_gpr (
        .clk(clk), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rs1(rs1), .rs2(rs2),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

endmodule

// File: bench/tb_rv_core.sv
module tb_rv_core
    import rv_pkg::*;
();

    localparam int prog_len   = 400;
    localparam int run_cycles = prog_len + 6;
    localparam int max_cycles = prog_len + 100;
    localparam logic [31:0] idle_word = 32'h0000_0003; // LB, not supported

    logic                  clk;
    logic                  rst_n;
    logic [xlen-1:0]       icache_data;
    logic [xlen-1:0]       icache_addr;
    logic                  wb_valid;
    logic [reg_addr_w-1:0] wb_rd;
    logic [xlen-1:0]       wb_data;

    integer      seed;
    logic [31:0] prog [0:prog_len-1];
    logic [31:0] model_regs [0:31];
    logic [4:0]  recent [0:2]; // Last three destinations
    logic [4:0]  exp_rd [$];
    logic [31:0] exp_data [$];
    int          exp_cycle [$];
    int          supported_count;
    int          retired_count;

    rv_core dut (
        .clk(clk), .rst_n(rst_n), .icache_data(icache_data), .icache_addr(icache_addr),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        #(max_cycles * 10);
        $display("Timeout after %0d cycles, the run did not complete", max_cycles);
        $display("Result: FAILED");
        $fatal(1, "Watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("Result: FAILED");
            $fatal(1, "Mismatch on %s", name);
        end
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return (r & 32'h7fff_ffff) % n;
    endfunction

    function automatic logic is_kept(input logic [31:0] w);
        return w[6:2] == op_op || w[6:2] == op_op_imm || w[6:2] == op_lui ||
               w[6:2] == op_auipc;
    endfunction

    function automatic logic [4:0] pick_src();
        logic [4:0] s;
        if (rand_below(2) == 0)
            s = recent[rand_below(3)];
        else
            s = 5'(rand_below(32));
        return s;
    endfunction

    function automatic logic [31:0] gen_word(input int k);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [4:0]  op;
        logic [2:0]  f3;
        logic [11:0] imm;
        logic        alt;
        logic [31:0] w;
        int          kind;
        rs1 = pick_src();
        rs2 = pick_src();
        f3  = 3'(rand_below(8));
        imm = 12'($random(seed));
        alt = 1'(rand_below(2));
        rd  = (rand_below(16) == 0) ? 5'd0 : 5'(rand_below(32));
        kind = rand_below(20);
        if (k < 31) begin // Prologue fills x1..x31 from x0
            rd   = 5'(k + 1);
            rs1  = 5'd0;
            f3   = 3'd0;
            kind = (k % 2 == 0) ? 10 : 17;
        end
        if (kind < 2) begin
            w  = 32'($random(seed));
            op = 5'(rand_below(32));
            w[6:0] = {op, 2'b11};
            while (is_kept(w)) begin
                op = 5'(rand_below(32));
                w[6:0] = {op, 2'b11};
            end
        end else if (kind < 10) begin
            w = {1'b0, alt & (f3 == 3'd0 || f3 == 3'd5), 5'd0, rs2, rs1, f3, rd, op_op, 2'b11};
        end else if (kind < 17) begin
            if (f3 == 3'd1 || f3 == 3'd5)
                imm = {1'b0, alt & (f3 == 3'd5), 5'd0, imm[4:0]}; // Shift forms
            w = {imm, rs1, f3, rd, op_op_imm, 2'b11};
        end else begin
            w = {20'($random(seed)), rd, (kind == 17) ? op_lui : op_auipc, 2'b11};
        end
        if (kind >= 2) begin
            recent[2] = recent[1];
            recent[1] = recent[0];
            recent[0] = rd;
        end
        return w;
    endfunction

    task automatic build_program();
        for (int i = 0; i < 32; i++)
            model_regs[i] = 32'd0;
        for (int i = 0; i < 3; i++)
            recent[i] = 5'd0;
        for (int k = 0; k < prog_len; k++)
            prog[k] = gen_word(k);
    endtask

    // Reference model, one supported word in program order
    task automatic predict_word(input logic [31:0] w, input logic [31:0] pc, input int cyc);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] r;
        logic [4:0]  sh;
        a  = model_regs[w[19:15]];
        b  = (w[6:2] == op_op) ? model_regs[w[24:20]] : {{20{w[31]}}, w[31:20]};
        sh = b[4:0];
        if (w[6:2] == op_lui) begin
            r = {w[31:12], 12'd0};
        end else if (w[6:2] == op_auipc) begin
            r = pc + {w[31:12], 12'd0};
        end else begin
            case (w[14:12])
                3'd0:    r = (w[6:2] == op_op && w[30]) ? a - b : a + b;
                3'd1:    r = a << sh;
                3'd2:    r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
                3'd3:    r = {31'd0, a < b};
                3'd4:    r = a ^ b;
                3'd5:    r = (a >> sh) | ((w[30] && a[31]) ? ~(32'hffff_ffff >> sh) : 32'd0);
                3'd6:    r = a | b;
                default: r = a & b;
            endcase
        end
        if (w[11:7] != 5'd0)
            model_regs[w[11:7]] = r;
        exp_rd.push_back(w[11:7]);
        exp_data.push_back(r);
        exp_cycle.push_back(cyc + 3); // Fixed three-cycle latency
        supported_count++;
    endtask

    task automatic check_outputs(input int cyc);
        logic due;
        due = (exp_cycle.size() > 0) && (exp_cycle[0] == cyc);
        check_value("icache_addr", icache_addr, reset_pc + 32'(4 * cyc));
        check_value("wb_valid", {31'd0, wb_valid}, {31'd0, due});
        if (wb_valid) begin
            check_value("wb_rd", {27'd0, wb_rd}, {27'd0, exp_rd[0]});
            check_value("wb_data", wb_data, exp_data[0]);
            void'(exp_rd.pop_front());
            void'(exp_data.pop_front());
            void'(exp_cycle.pop_front());
            retired_count++;
        end
    endtask

    task automatic drive_word(input int cyc);
        int          idx;
        logic [31:0] w;
        idx = int'((icache_addr - reset_pc) >> 2);
        w   = (idx < prog_len) ? prog[idx] : idle_word;
        icache_data = w;
        if (is_kept(w))
            predict_word(w, icache_addr, cyc);
    endtask

    initial begin
        seed            = 32'h6ca6;
        rst_n           = 1'b0;
        icache_data     = idle_word;
        supported_count = 0;
        retired_count   = 0;
        build_program();
        repeat (2) @(posedge clk);
        for (int cyc = 0; cyc < run_cycles; cyc++) begin
            @(negedge clk);
            rst_n = 1'b1;
            check_outputs(cyc); // Outputs settled since the rising edge
            drive_word(cyc);
        end
        if (retired_count == supported_count && exp_rd.size() == 0) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            $display("Retired %0d of %0d supported instructions", retired_count,
                     supported_count);
            $display("Result: FAILED");
            $fatal(1, "Retirement count does not match the program");
        end
    end

endmodule

// File: project.f
rtl/rv_pkg.sv
rtl/fetch_unit.sv
rtl/inst_decoder.sv
rtl/id_stage.sv
rtl/alu.sv
rtl/ma_stage.sv
rtl/gpr_file.sv
rtl/rv_core.sv
bench/tb_rv_core.sv

// File: run.sh
#!/bin/sh
# Build and run the rv_core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_rv_core -f project.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vtb_rv_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
exit 1
